// File: Bender.yml
package:
  name: axi_read_demux

export_include_dirs:
  - .

sources:
  - demux_pkg.sv
  - order_if.sv
  - id_order_table.sv
  - rr_arbiter.sv
  - ar_router.sv
  - r_merge.sv
  - axi_read_demux.sv
  - target: test
    files:
      - demux_chk.sv
      - tb_axi_read_demux.sv

// File: ar_router.sv
// AR router of the AXI read demultiplexer
// Region decode, per-ID ordering check, slave lock and AR fan-out to the slaves
`include "demux_macros.svh"

module ar_router (
    input  logic                        clk,
    input  logic                        rstn,
    order_if.router                     ord,
    input  logic                        ar_valid,
    output logic                        ar_ready,
    input  demux_pkg::id_t              ar_id,
    input  demux_pkg::addr_t            ar_addr,
    input  demux_pkg::len_t             ar_len,
    output logic [`DEMUX_SLAVE_NUM-1:0] s_ar_valid,
    input  logic [`DEMUX_SLAVE_NUM-1:0] s_ar_ready,
    output demux_pkg::id_t              s_ar_id,
    output demux_pkg::addr_t            s_ar_addr,
    output demux_pkg::len_t             s_ar_len
);
    import demux_pkg::*;

    localparam addr_t region_mask = addr_t'((1 << `DEMUX_REGION_BITS) - 1);

    slave_idx_t match_idx;
    logic       forward;
    logic       locked;
    slave_idx_t sel_q;

    // Slave i owns the region based at i << REGION_BITS
    // An address outside every region falls back to slave 0
    always_comb begin
        match_idx = '0;
        for (int i = 0; i < `DEMUX_SLAVE_NUM; i++) begin
            if ((ar_addr & ~region_mask) == (addr_t'(i) << `DEMUX_REGION_BITS)) begin
                match_idx = slave_idx_t'(i);
            end
        end
    end

    // The ID is free, or it already belongs to this slave and has room for one more read
    assign ord.lookup_id = ar_id;
    assign forward = ar_valid && (ord.lookup_entry.count == '0 ||
        (ord.lookup_entry.owner == match_idx && ord.lookup_entry.count != `DEMUX_CNT_MAX));

    // Hold the chosen slave from the cycle after ar_valid until the handshake
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            locked <= 1'b0;
            sel_q  <= '0;
        end else if (locked) begin
            // ar_valid stays high while locked, so ready alone marks the handshake
            if (ar_ready) begin
                locked <= 1'b0;
            end
        end else if (forward) begin
            locked <= 1'b1;
            sel_q  <= match_idx;
        end
    end

    // Payload goes to every slave, only the selected one sees valid
    assign s_ar_id   = ar_id;
    assign s_ar_addr = ar_addr;
    assign s_ar_len  = ar_len;
    for (genvar i = 0; i < `DEMUX_SLAVE_NUM; i++) begin : g_valid
        assign s_ar_valid[i] = locked && sel_q == slave_idx_t'(i);
    end

    assign ar_ready = locked && s_ar_ready[sel_q];

    // Every accepted AR counts against its ID in the order table
    assign ord.issue       = ar_valid && ar_ready;
    assign ord.issue_slave = sel_q;

endmodule

// File: axi_read_demux.sv
// Top level of the AXI read demultiplexer with one master and four slaves
// Connects the AR router, the R merger and the per-ID order table
`include "demux_macros.svh"

module axi_read_demux (
    input  logic                        clk,
    input  logic                        rstn,
    // Master AR channel
    input  logic                        ar_valid,
    output logic                        ar_ready,
    input  demux_pkg::id_t              ar_id,
    input  demux_pkg::addr_t            ar_addr,
    input  demux_pkg::len_t             ar_len,
    // Master R channel
    output logic                        r_valid,
    input  logic                        r_ready,
    output demux_pkg::id_t              r_id,
    output demux_pkg::data_t            r_data,
    output demux_pkg::resp_t            r_resp,
    output logic                        r_last,
    // Slave AR channels, the payload is shared
    output logic [`DEMUX_SLAVE_NUM-1:0] s_ar_valid,
    input  logic [`DEMUX_SLAVE_NUM-1:0] s_ar_ready,
    output demux_pkg::id_t              s_ar_id,
    output demux_pkg::addr_t            s_ar_addr,
    output demux_pkg::len_t             s_ar_len,
    // Slave R channels
    input  logic [`DEMUX_SLAVE_NUM-1:0] s_r_valid,
    output logic [`DEMUX_SLAVE_NUM-1:0] s_r_ready,
    input  demux_pkg::id_t              s_r_id [`DEMUX_SLAVE_NUM],
    input  demux_pkg::data_t            s_r_data [`DEMUX_SLAVE_NUM],
    input  demux_pkg::resp_t            s_r_resp [`DEMUX_SLAVE_NUM],
    input  logic                        s_r_last [`DEMUX_SLAVE_NUM]
);

    // Lookup, issue and retire between the three blocks
    order_if ord_if (.clk(clk));

    id_order_table u_table (
        .clk  (clk),
        .rstn (rstn),
        .ord  (ord_if)
    );

    ar_router u_router (
        .clk        (clk),
        .rstn       (rstn),
        .ord        (ord_if),
        .ar_valid   (ar_valid),
        .ar_ready   (ar_ready),
        .ar_id      (ar_id),
        .ar_addr    (ar_addr),
        .ar_len     (ar_len),
        .s_ar_valid (s_ar_valid),
        .s_ar_ready (s_ar_ready),
        .s_ar_id    (s_ar_id),
        .s_ar_addr  (s_ar_addr),
        .s_ar_len   (s_ar_len)
    );

    r_merge u_merge (
        .clk       (clk),
        .rstn      (rstn),
        .ord       (ord_if),
        .r_valid   (r_valid),
        .r_ready   (r_ready),
        .r_id      (r_id),
        .r_data    (r_data),
        .r_resp    (r_resp),
        .r_last    (r_last),
        .s_r_valid (s_r_valid),
        .s_r_ready (s_r_ready),
        .s_r_id    (s_r_id),
        .s_r_data  (s_r_data),
        .s_r_resp  (s_r_resp),
        .s_r_last  (s_r_last)
    );

endmodule

// File: demux_chk.sv
// Concurrent assertions on the top-level handshakes of the AXI read demultiplexer
// Bound into the top level, counts its own failures
`include "demux_macros.svh"

module demux_chk (
    input logic                        clk,
    input logic                        rstn,
    input logic                        ar_valid,
    input logic                        ar_ready,
    input demux_pkg::id_t              ar_id,
    input demux_pkg::addr_t            ar_addr,
    input demux_pkg::len_t             ar_len,
    input logic                        r_valid,
    input logic                        r_ready,
    input logic [`DEMUX_SLAVE_NUM-1:0] s_ar_valid
);
    // Number of assertion failures so far
    int assert_errors = 0;

    // The merger only offers a beat while the master can take it
    r_valid_needs_ready: assert property (@(posedge clk) disable iff (!rstn) r_valid |-> r_ready)
        else begin
            $error("r_valid high while r_ready is low");
            assert_errors++;
        end

    // The router never addresses two slaves at once
    one_slave_selected: assert property (@(posedge clk) disable iff (!rstn) $onehot0(s_ar_valid))
        else begin
            $error("more than one s_ar_valid high");
            assert_errors++;
        end

    // A pending AR keeps valid and payload until ready
    ar_held_until_ready: assert property (@(posedge clk) disable iff (!rstn)
        ar_valid && !ar_ready |=> ar_valid && $stable({ar_id, ar_addr, ar_len}))
        else begin
            $error("AR request dropped or changed before ar_ready");
            assert_errors++;
        end

endmodule

bind axi_read_demux demux_chk u_chk (.*);

// File: demux_input.txt
# Columns are id, addr, len and idle cycles before the request
# id, addr and len are hex, idle is decimal
1 1000 3 0
1 1010 0 0
1 1020 1 0
1 1030 2 0
2 2100 0 1
2 3200 2 0
0 0040 1 2
0 8000 0 0
3 3ff0 7 0
3 1004 0 0
0 f123 2 3
2 2008 1 0
1 0100 4 0
3 3000 0 1
0 4000 0 0
2 0ffc 2 0

// File: demux_macros.svh
// Width and size macros for the AXI read demultiplexer
// Slave count, AXI field widths, address regions and the per-ID counter limit
`ifndef DEMUX_MACROS_SVH
`define DEMUX_MACROS_SVH

// Number of slaves and the width of a slave index
`define DEMUX_SLAVE_NUM 4
`define DEMUX_SLAVE_WIDTH 2

// AXI field widths
`define DEMUX_ID_WIDTH 2
`define DEMUX_ID_NUM (1 << `DEMUX_ID_WIDTH)
`define DEMUX_ADDR_WIDTH 16
`define DEMUX_DATA_WIDTH 32
`define DEMUX_LEN_WIDTH 4

// Low address bits inside one region, so slave i starts at i << 12
`define DEMUX_REGION_BITS 12

// Outstanding reads per ID saturate at the all-ones counter value
`define DEMUX_CNT_WIDTH 2
`define DEMUX_CNT_MAX ((1 << `DEMUX_CNT_WIDTH) - 1)

`endif

// File: demux_pkg.sv
// Shared types of the AXI read demultiplexer
// Field types of the AR and R channels, the packed R beat and the order-table entry
`include "demux_macros.svh"

package demux_pkg;

    // Plain field types
    typedef logic [`DEMUX_SLAVE_WIDTH-1:0] slave_idx_t;
    typedef logic [`DEMUX_ID_WIDTH-1:0]    id_t;
    typedef logic [`DEMUX_ADDR_WIDTH-1:0]  addr_t;
    typedef logic [`DEMUX_DATA_WIDTH-1:0]  data_t;
    typedef logic [1:0]                    resp_t;
    typedef logic [`DEMUX_LEN_WIDTH-1:0]   len_t;

    // One R beat as it travels from a slave to the master
    typedef struct packed {
        id_t   id;
        data_t data;
        resp_t resp;
        logic  last;
    } r_beat_t;

    // The slave that currently owns an ID, and how many reads it still owes
    typedef struct packed {
        slave_idx_t                  owner;
        logic [`DEMUX_CNT_WIDTH-1:0] count;
    } order_entry_t;

endpackage

// File: id_order_table.sv
// Per-ID order table of the AXI read demultiplexer
// Keeps the owning slave and the outstanding read count of every ID
`include "demux_macros.svh"

module id_order_table (
    input logic       clk,
    input logic       rstn,
    order_if.ord_table ord
);
    import demux_pkg::*;

    order_entry_t entries [`DEMUX_ID_NUM];

    // One increment and one decrement strobe per ID
    logic [`DEMUX_ID_NUM-1:0] incr;
    logic [`DEMUX_ID_NUM-1:0] decr;

    for (genvar i = 0; i < `DEMUX_ID_NUM; i++) begin : g_strobe
        assign incr[i] = ord.issue && ord.lookup_id == id_t'(i);
        assign decr[i] = ord.retire && ord.retire_id == id_t'(i);
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int i = 0; i < `DEMUX_ID_NUM; i++) begin
                entries[i] <= '0;
            end
        end else begin
            for (int i = 0; i < `DEMUX_ID_NUM; i++) begin
                if (incr[i]) begin
                    // The issuing slave becomes the owner, which only changes while the count is zero
                    entries[i].owner <= ord.issue_slave;
                    // An issue and a retire together cancel out
                    if (!decr[i]) begin
                        entries[i].count <= entries[i].count + 1'b1;
                    end
                end else if (decr[i]) begin
                    entries[i].count <= entries[i].count - 1'b1;
                end
            end
        end
    end

    // The router sees the entry of the pending AR without delay
    assign ord.lookup_entry = entries[ord.lookup_id];

endmodule

// File: order_if.sv
// Ordering interface between the AR router, the ID order table and the R merger
// Carries the table lookup, the issue strobe and the retire strobe
interface order_if (
    input logic clk
);
    import demux_pkg::*;

    // Lookup of the entry for the ID on the master AR channel
    id_t          lookup_id;
    order_entry_t lookup_entry;

    // A new read with ID lookup_id was accepted and sent to issue_slave
    logic         issue;
    slave_idx_t   issue_slave;

    // The last beat of a read for retire_id went to the master
    logic         retire;
    id_t          retire_id;

    modport router (input clk, output lookup_id, input lookup_entry,
                    output issue, output issue_slave);
    // The order table answers the lookup and applies issue and retire
    modport ord_table (input clk, input lookup_id, output lookup_entry,
                       input issue, input issue_slave, input retire, input retire_id);
    modport merger (input clk, output retire, output retire_id);

endinterface

// File: r_merge.sv
// R channel merger of the AXI read demultiplexer
// Round-robin choice among the slaves, beat multiplexing and the retire strobe
`include "demux_macros.svh"

module r_merge (
    input  logic                        clk,
    input  logic                        rstn,
    order_if.merger                     ord,
    output logic                        r_valid,
    input  logic                        r_ready,
    output demux_pkg::id_t              r_id,
    output demux_pkg::data_t            r_data,
    output demux_pkg::resp_t            r_resp,
    output logic                        r_last,
    input  logic [`DEMUX_SLAVE_NUM-1:0] s_r_valid,
    output logic [`DEMUX_SLAVE_NUM-1:0] s_r_ready,
    input  demux_pkg::id_t              s_r_id [`DEMUX_SLAVE_NUM],
    input  demux_pkg::data_t            s_r_data [`DEMUX_SLAVE_NUM],
    input  demux_pkg::resp_t            s_r_resp [`DEMUX_SLAVE_NUM],
    input  logic                        s_r_last [`DEMUX_SLAVE_NUM]
);
    import demux_pkg::*;

    r_beat_t                     beats [`DEMUX_SLAVE_NUM];
    r_beat_t                     out_beat;
    logic [`DEMUX_SLAVE_NUM-1:0] grant;
    slave_idx_t                  grant_idx;

    for (genvar i = 0; i < `DEMUX_SLAVE_NUM; i++) begin : g_pack
        assign beats[i] = '{id: s_r_id[i], data: s_r_data[i], resp: s_r_resp[i],
                            last: s_r_last[i]};
    end

    // Arbitrate only while the master is ready, so the winner transfers in the same cycle
    rr_arbiter u_arb (
        .clk     (clk),
        .rstn    (rstn),
        .enable  (r_ready),
        .request (s_r_valid),
        .grant   (grant)
    );

    always_comb begin
        grant_idx = '0;
        for (int i = 0; i < `DEMUX_SLAVE_NUM; i++) begin
            if (grant[i]) begin
                grant_idx = slave_idx_t'(i);
            end
        end
    end

    assign out_beat = beats[grant_idx];
    assign r_id     = out_beat.id;
    assign r_data   = out_beat.data;
    assign r_resp   = out_beat.resp;
    assign r_last   = out_beat.last;

    // r_valid follows r_ready, which makes every offered beat a completed transfer
    assign r_valid = r_ready && |grant;
    for (genvar i = 0; i < `DEMUX_SLAVE_NUM; i++) begin : g_ready
        assign s_r_ready[i] = r_ready && grant[i];
    end

    // The last beat of a burst releases one outstanding read of its ID
    assign ord.retire    = r_valid && r_ready && out_beat.last;
    assign ord.retire_id = out_beat.id;

endmodule

// File: rr_arbiter.sv
// Round-robin arbiter over the slave requests
// The search starts one place after the last winner and the pointer moves only when enabled
`include "demux_macros.svh"

module rr_arbiter (
    input  logic                        clk,
    input  logic                        rstn,
    input  logic                        enable,
    input  logic [`DEMUX_SLAVE_NUM-1:0] request,
    output logic [`DEMUX_SLAVE_NUM-1:0] grant
);
    localparam int last_slave = `DEMUX_SLAVE_NUM - 1;

    // Index of the last winner
    logic [`DEMUX_SLAVE_WIDTH-1:0] ptr_q;
    logic [`DEMUX_SLAVE_WIDTH-1:0] win_idx;

    always_comb begin : pick
        int   idx;
        logic found;
        grant   = '0;
        win_idx = ptr_q;
        found   = 1'b0;
        // Walk once around the ring, nearest requester after the pointer wins
        for (int k = 1; k <= `DEMUX_SLAVE_NUM; k++) begin
            idx = (int'(ptr_q) + k) % `DEMUX_SLAVE_NUM;
            if (!found && request[idx]) begin
                found        = 1'b1;
                grant[idx]   = 1'b1;
                win_idx      = idx[`DEMUX_SLAVE_WIDTH-1:0];
            end
        end
    end

    // After reset the pointer sits on the last slave so that slave 0 has priority
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            ptr_q <= last_slave[`DEMUX_SLAVE_WIDTH-1:0];
        end else if (enable && |grant) begin
            ptr_q <= win_idx;
        end
    end

endmodule

// File: tb_axi_read_demux.sv
// Testbench for the AXI read demultiplexer
// Request file reader, master AR driver, four random slave models, R scoreboard, watchdog
`include "demux_macros.svh"

module tb_axi_read_demux;
    import demux_pkg::*;

    // One read with the slave that the region rule picks or that accepted it
    typedef struct packed {
        slave_idx_t slave;
        id_t        id;
        addr_t      addr;
        len_t       len;
    } req_t;

    localparam int read_limit  = 3;
    localparam int hold_cycles = 60;

    logic                        clk;
    logic                        rstn;
    logic                        ar_valid, ar_ready, r_valid, r_ready, r_last;
    id_t                         ar_id, r_id, s_ar_id;
    addr_t                       ar_addr, s_ar_addr;
    len_t                        ar_len, s_ar_len;
    data_t                       r_data;
    resp_t                       r_resp;
    logic [`DEMUX_SLAVE_NUM-1:0] s_ar_valid, s_ar_ready, s_r_valid, s_r_ready;
    id_t                         s_r_id [`DEMUX_SLAVE_NUM];
    data_t                       s_r_data [`DEMUX_SLAVE_NUM];
    resp_t                       s_r_resp [`DEMUX_SLAVE_NUM];
    logic                        s_r_last [`DEMUX_SLAVE_NUM];

    // File requests, reads open at the master and ARs held by the slave models
    req_t                        req_q[$];
    int                          idle_q[$];
    req_t                        exp_q[$];
    req_t                        pend_q[$];
    int                          rx_beat [`DEMUX_ID_NUM];
    int                          outstanding [`DEMUX_ID_NUM];
    slave_idx_t                  owner [`DEMUX_ID_NUM];
    int                          tx_beat [`DEMUX_SLAVE_NUM];
    logic [`DEMUX_SLAVE_NUM-1:0] s_r_hs;
    int                          cycle;
    integer                      seed;
    logic                        file_read;

    axi_read_demux uut (.*);

    // Slave i owns the 4 KiB region at i << 12 and any other address belongs to slave 0
    function automatic slave_idx_t region_slave(addr_t addr);
        int region;
        region = int'(addr >> 12);
        return (region < `DEMUX_SLAVE_NUM) ? slave_idx_t'(region) : slave_idx_t'(0);
    endfunction

    // The next R beat of an ID belongs to the oldest open read of that ID
    function automatic int find_expected(id_t id);
        for (int i = 0; i < exp_q.size(); i++) begin
            if (exp_q[i].id == id) begin
                return i;
            end
        end
        return -1;
    endfunction

    // Oldest AR that a slave model still has to answer
    function automatic int find_pending(int s);
        for (int i = 0; i < pend_q.size(); i++) begin
            if (pend_q[i].slave == slave_idx_t'(s)) begin
                return i;
            end
        end
        return -1;
    endfunction

    task automatic abort_run();
        $display("TESTS FAILED");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
        if (got !== exp) begin
            $display("FAIL %s: got 0x%0h, expected 0x%0h", name, got, exp);
            abort_run();
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Each request waits its idle cycles and then holds AR until the handshake
    task automatic drive_requests();
        repeat (5) @(posedge clk);
        #1;
        rstn = 1'b1;
        foreach (req_q[i]) begin
            repeat (idle_q[i]) begin
                @(posedge clk);
                #1;
            end
            ar_valid = 1'b1;
            ar_id    = req_q[i].id;
            ar_addr  = req_q[i].addr;
            ar_len   = req_q[i].len;
            @(negedge clk);
            while (!ar_ready) begin
                @(negedge clk);
            end
            @(posedge clk);
            #1;
            ar_valid = 1'b0;
        end
    endtask

    initial begin : main
        int          fd;
        int          idle;
        logic [31:0] id_v;
        logic [31:0] addr_v;
        logic [31:0] len_v;
        string       line;
        req_t        req;
        seed       = 32'h63f6_2e6f;
        file_read  = 1'b0;
        cycle      = 0;
        s_r_hs     = '0;
        rstn       = 1'b0;
        ar_valid   = 1'b0;
        ar_id      = '0;
        ar_addr    = '0;
        ar_len     = '0;
        r_ready    = 1'b1;
        // Slaves are ready during reset, so ar_ready shows the router state
        s_ar_ready = '1;
        s_r_valid  = '0;
        for (int s = 0; s < `DEMUX_SLAVE_NUM; s++) begin
            s_r_id[s]   = '0;
            s_r_data[s] = '0;
            s_r_resp[s] = '0;
            s_r_last[s] = 1'b0;
            tx_beat[s]  = 0;
        end
        for (int i = 0; i < `DEMUX_ID_NUM; i++) begin
            rx_beat[i]     = 0;
            outstanding[i] = 0;
            owner[i]       = '0;
        end
        // Lines without four fields, like the column comments, are skipped
        fd = $fopen("demux_input.txt", "r");
        while (fd != 0 && !$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if ($sscanf(line, "%h %h %h %d", id_v, addr_v, len_v, idle) == 4) begin
                req = '{slave: region_slave(addr_v[15:0]), id: id_v[1:0],
                        addr: addr_v[15:0], len: len_v[3:0]};
                req_q.push_back(req);
                idle_q.push_back(idle);
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end
        file_read = 1'b1;
        if (req_q.size() == 0) begin
            $display("No read requests could be read from demux_input.txt");
            abort_run();
        end else begin
            drive_requests();
            // Every read has to come back and every slave model has to run dry
            while (exp_q.size() != 0 || pend_q.size() != 0) begin
                @(posedge clk);
            end
            repeat (5) @(posedge clk);
            if (uut.u_chk.assert_errors == 0) begin
                $display("TESTS PASSED");
                $finish;
            end else begin
                $display("Bound assertions failed %0d times", uut.u_chk.assert_errors);
                abort_run();
            end
        end
    end

    // Everything is sampled on the falling edge, where DUT outputs are settled
    always @(negedge clk) begin : monitor
        int          k;
        logic [31:0] exp_data;
        req_t        req;
        if (!rstn) begin
            check_value("s_ar_valid", 32'(s_ar_valid), 32'h0);
            check_value("ar_ready", 32'(ar_ready), 32'h0);
            check_value("r_valid", 32'(r_valid), 32'h0);
        end else begin
            cycle = cycle + 1;
            if (uut.u_chk.assert_errors != 0) begin
                $display("A bound assertion on the top-level handshakes failed");
                abort_run();
            end
            // An accepted AR keeps its ID on one slave and under the read limit
            if (ar_valid && ar_ready) begin
                if (outstanding[ar_id] >= read_limit) begin
                    $display("Read of ID %0h forwarded with three reads still open", ar_id);
                    abort_run();
                end
                if (outstanding[ar_id] != 0) begin
                    check_value("ar owner", 32'(region_slave(ar_addr)), 32'(owner[ar_id]));
                end
                outstanding[ar_id] = outstanding[ar_id] + 1;
                owner[ar_id]       = region_slave(ar_addr);
                req = '{slave: region_slave(ar_addr), id: ar_id, addr: ar_addr, len: ar_len};
                exp_q.push_back(req);
            end
            for (int s = 0; s < `DEMUX_SLAVE_NUM; s++) begin
                if (s_ar_valid[s] && s_ar_ready[s]) begin
                    check_value("s_ar_valid index", s, 32'(region_slave(s_ar_addr)));
                    req = '{slave: slave_idx_t'(s), id: s_ar_id, addr: s_ar_addr,
                            len: s_ar_len};
                    pend_q.push_back(req);
                end
            end
            s_r_hs = s_r_valid & s_r_ready;
            // Each beat continues the oldest open read of its ID
            if (r_valid && r_ready) begin
                k = find_expected(r_id);
                if (k < 0) begin
                    $display("R beat for ID %0h arrived with no open read", r_id);
                    abort_run();
                end else begin
                    exp_data = {6'd0, exp_q[k].slave, 8'(rx_beat[r_id]), exp_q[k].addr};
                    check_value("r_data", r_data, exp_data);
                    check_value("r_resp", 32'(r_resp), 32'h0);
                    check_value("r_last", 32'(r_last), 32'(rx_beat[r_id] == exp_q[k].len));
                    if (r_last) begin
                        exp_q.delete(k);
                        rx_beat[r_id]     = 0;
                        outstanding[r_id] = outstanding[r_id] - 1;
                    end else begin
                        rx_beat[r_id] = rx_beat[r_id] + 1;
                    end
                end
            end
        end
    end

    // Slave models and master r_ready change just after the rising edge, with random stalls
    always @(posedge clk) begin : slave_models
        int          k;
        logic [31:0] rnd;
        #1;
        if (cycle > 0) begin
            rnd        = $random(seed);
            s_ar_ready = rnd[3:0];
            r_ready    = rnd[5:4] != 2'b00;
            for (int s = 0; s < `DEMUX_SLAVE_NUM; s++) begin
                k = find_pending(s);
                // The beat on offer went out at the last edge
                if (s_r_hs[s]) begin
                    if (tx_beat[s] == int'(pend_q[k].len)) begin
                        pend_q.delete(k);
                        tx_beat[s] = 0;
                    end else begin
                        tx_beat[s] = tx_beat[s] + 1;
                    end
                    k = find_pending(s);
                end
                rnd = $random(seed);
                // A beat still waiting for ready keeps its valid and payload
                if (!s_r_valid[s] || s_r_hs[s]) begin
                    s_r_valid[s] = k >= 0 && cycle > hold_cycles && rnd[0];
                    if (k >= 0) begin
                        s_r_id[s]   = pend_q[k].id;
                        s_r_data[s] = {6'd0, slave_idx_t'(s), 8'(tx_beat[s]), pend_q[k].addr};
                        s_r_resp[s] = '0;
                        s_r_last[s] = tx_beat[s] == int'(pend_q[k].len);
                    end
                end
            end
        end
    end

    // Each request gets 200 cycles, plus some slack for reset and the drain
    initial begin : watchdog
        wait (file_read);
        repeat (200 * req_q.size() + 100) @(posedge clk);
        $display("Timeout, the reads did not all complete in time");
        abort_run();
    end

endmodule

// File: vlog.f
+incdir+.
demux_pkg.sv
order_if.sv
id_order_table.sv
rr_arbiter.sv
ar_router.sv
r_merge.sv
axi_read_demux.sv
demux_chk.sv
tb_axi_read_demux.sv
